//--- Makefile
VERILATOR ?= verilator
TOP       ?= alu_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
+incdir+logic
logic/alu_op_pkg.sv
logic/alu_result_pkg.sv
logic/cond_eval.sv
logic/alu_datapath.sv
logic/flag_gen.sv
logic/result_queue.sv
logic/alu_core.sv
verif/alu_tb.sv

//--- logic/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// operand and result width
`define ALU_DATA_W 64

// C,O,A,S,Z,P
`define ALU_FLAGS_W 6

// issue tag wide enough for all in-flight ops
`define ALU_TAG_W 4

// result queue entries and the issuer's credits after reset
`define ALU_QUEUE_DEPTH 4

// credits the sink hands out after reset
`define ALU_SINK_CREDITS 2

`endif

//--- logic/alu_core.sv
`timescale 1ns/1ps

module alu_core import alu_op_pkg::*; import alu_result_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  alu_issue_t  issue,
  input  logic        issue_valid,
  output logic        issue_credit,
  output alu_result_t result,
  output logic        result_valid,
  input  logic        result_credit
);

  alu_result_t stage;
  logic        stage_valid;
  logic        carry_out;
  logic        carry_nibble;
  logic        sign_a;
  logic        sign_b;
  alu_opcode_e stage_op;
  alu_size_e   stage_size;
  logic        stage_no_flags;
  alu_result_t done;
  logic        done_valid;

  alu_datapath i_alu_datapath (
    .clk            (clk),
    .rst            (rst),
    .issue          (issue),
    .issue_valid    (issue_valid),
    .stage          (stage),
    .stage_valid    (stage_valid),
    .carry_out      (carry_out),
    .carry_nibble   (carry_nibble),
    .sign_a         (sign_a),
    .sign_b         (sign_b),
    .stage_op       (stage_op),
    .stage_size     (stage_size),
    .stage_no_flags (stage_no_flags)
  );

  flag_gen i_flag_gen (
    .stage        (stage),
    .stage_valid  (stage_valid),
    .carry_out    (carry_out),
    .carry_nibble (carry_nibble),
    .sign_a       (sign_a),
    .sign_b       (sign_b),
    .stage_op     (stage_op),
    .stage_size   (stage_size),
    .no_flags     (stage_no_flags),
    .done         (done),
    .done_valid   (done_valid)
  );

  result_queue i_result_queue (
    .clk           (clk),
    .rst           (rst),
    .done          (done),
    .done_valid    (done_valid),
    .result        (result),
    .result_valid  (result_valid),
    .result_credit (result_credit),
    .issue_credit  (issue_credit)
  );

endmodule

//--- logic/alu_datapath.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_datapath import alu_op_pkg::*; import alu_result_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  alu_issue_t  issue,
  input  logic        issue_valid,
  output alu_result_t stage,
  output logic        stage_valid,
  output logic        carry_out,
  output logic        carry_nibble,
  output logic        sign_a,
  output logic        sign_b,
  output alu_opcode_e stage_op,
  output alu_size_e   stage_size,
  output logic        stage_no_flags
);

  logic                 is_sub;
  logic                 is_32;
  logic                 taken;
  alu_data_t            b_in;
  logic [`ALU_DATA_W:0] sum_ext;
  logic                 carry32;
  logic                 carry4;
  alu_data_t            value;

  cond_eval i_cond_eval (
    .flags (alu_flags_t'(issue.flags_in)),
    .cond  (issue.cond),
    .taken (taken)
  );

  assign is_sub = (issue.opcode == SUB);
  assign is_32  = (issue.size == SZ32);

  // sub is a + ~b + 1
  assign b_in    = is_sub ? ~issue.b : issue.b;
  assign sum_ext = {1'b0, issue.a} + {1'b0, b_in} + {{`ALU_DATA_W{1'b0}}, is_sub};

  // carry into a bit = sum bit xor both operand bits
  assign carry32 = sum_ext[32] ^ issue.a[32] ^ b_in[32];
  assign carry4  = sum_ext[4] ^ issue.a[4] ^ b_in[4];

  always_comb begin
    case (issue.opcode)
      ADD, SUB: value = sum_ext[`ALU_DATA_W-1:0];
      AND:      value = issue.a & issue.b;
      OR:       value = issue.a | issue.b;
      XOR:      value = issue.a ^ issue.b;
      MOV:      value = issue.b;
      ZXT8:     value = alu_data_t'(issue.b[7:0]);
      ZXT16:    value = alu_data_t'(issue.b[15:0]);
      SXT8:     value = alu_data_t'($signed(issue.b[7:0]));
      SXT16:    value = alu_data_t'($signed(issue.b[15:0]));
      SXT32:    value = alu_data_t'($signed(issue.b[31:0]));
      CMOV:     value = taken ? issue.b : issue.a;
      CSET:     value = alu_data_t'(taken);
      default:  value = '0;
    endcase
    if (is_32) begin
      value[`ALU_DATA_W-1:32] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= issue_valid;
    end
  end

  // payload only moves on a valid issue
  always_ff @(posedge clk) begin
    if (issue_valid) begin
      stage.tag        <= issue.tag;
      stage.value      <= value;
      stage.flags      <= '0;  // filled in by flag_gen
      stage.sets_flags <= 1'b0;
      carry_out        <= is_32 ? carry32 : sum_ext[`ALU_DATA_W];
      carry_nibble     <= carry4;
      sign_a           <= is_32 ? issue.a[31] : issue.a[`ALU_DATA_W-1];
      sign_b           <= is_32 ? issue.b[31] : issue.b[`ALU_DATA_W-1];
      stage_op         <= issue.opcode;
      stage_size       <= issue.size;
      stage_no_flags   <= issue.no_flags;
    end
  end

endmodule

//--- logic/alu_op_pkg.sv
`include "alu_config.svh"

package alu_op_pkg;

  typedef logic [`ALU_DATA_W-1:0] alu_data_t;
  typedef logic [`ALU_TAG_W-1:0]  alu_tag_t;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    MOV,
    ZXT8,
    ZXT16,
    SXT8,
    SXT16,
    SXT32,
    CMOV,
    CSET
  } alu_opcode_e;

  typedef enum logic {
    SZ64,
    SZ32
  } alu_size_e;

  // 16 flag tests plus always
  typedef enum logic [4:0] {
    Z, NZ, S, NS,
    UGT, ULE, UGE, ULT,
    SGT, SLE, SGE, SLT,
    O, NO, P, NP,
    ALWAYS
  } alu_cond_e;

  typedef struct packed {
    alu_tag_t                 tag;
    alu_opcode_e              opcode;
    alu_size_e                size;
    alu_cond_e                cond;
    logic                     no_flags;  // result keeps flags cleared
    alu_data_t                a;
    alu_data_t                b;
    logic [`ALU_FLAGS_W-1:0]  flags_in;  // C,O,A,S,Z,P for cmov/cset
  } alu_issue_t;

endpackage

//--- logic/alu_result_pkg.sv
package alu_result_pkg;

  import alu_op_pkg::*;

  // same bit order as issue flags_in
  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } alu_flags_t;

  typedef struct packed {
    alu_tag_t   tag;
    alu_data_t  value;
    alu_flags_t flags;
    logic       sets_flags;
  } alu_result_t;

endpackage

//--- logic/cond_eval.sv
`timescale 1ns/1ps

module cond_eval import alu_op_pkg::*; import alu_result_pkg::*; (
  input  alu_flags_t flags,
  input  alu_cond_e  cond,
  output logic       taken
);

  logic lt;  // signed less-than

  assign lt = flags.s ^ flags.o;

  always_comb begin
    case (cond)
      Z:       taken = flags.z;
      NZ:      taken = ~flags.z;
      S:       taken = flags.s;
      NS:      taken = ~flags.s;
      UGT:     taken = ~(flags.c | flags.z);
      ULE:     taken = flags.c | flags.z;
      UGE:     taken = ~flags.c;
      ULT:     taken = flags.c;
      SGT:     taken = ~(lt | flags.z);
      SLE:     taken = lt | flags.z;
      SGE:     taken = ~lt;
      SLT:     taken = lt;
      O:       taken = flags.o;
      NO:      taken = ~flags.o;
      P:       taken = flags.p;
      NP:      taken = ~flags.p;
      ALWAYS:  taken = 1'b1;
      default: taken = 1'b0;  // unused encodings
    endcase
  end

endmodule

//--- logic/flag_gen.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module flag_gen import alu_op_pkg::*; import alu_result_pkg::*; (
  input  alu_result_t stage,
  input  logic        stage_valid,
  input  logic        carry_out,
  input  logic        carry_nibble,
  input  logic        sign_a,
  input  logic        sign_b,
  input  alu_opcode_e stage_op,
  input  alu_size_e   stage_size,
  input  logic        no_flags,
  output alu_result_t done,
  output logic        done_valid
);

  logic                    is_add;
  logic                    is_sub;
  logic                    is_logic;
  logic                    top;
  logic                    zero;
  logic                    parity;
  logic                    add_of;
  logic                    sub_of;
  logic                    sets;
  logic [`ALU_FLAGS_W-1:0] flags_coaszp;

  assign is_add   = (stage_op == ADD);
  assign is_sub   = (stage_op == SUB);
  assign is_logic = (stage_op == AND) || (stage_op == OR) || (stage_op == XOR);

  // sized sign and zero test
  assign top  = (stage_size == SZ32) ? stage.value[31] : stage.value[`ALU_DATA_W-1];
  assign zero = (stage_size == SZ32) ? (stage.value[31:0] == '0) : (stage.value == '0);

  assign parity = ~^stage.value[7:0];  // even count of ones

  assign add_of = (sign_a == sign_b) && (top != sign_a);
  assign sub_of = (sign_a != sign_b) && (top != sign_a);

  assign sets = (is_add || is_sub || is_logic) && !no_flags;

  always_comb begin
    if (!sets) begin
      flags_coaszp = '0;
    end else if (is_add) begin
      flags_coaszp = {carry_out, add_of, carry_nibble, top, zero, parity};
    end else if (is_sub) begin
      // borrow is the inverted carry
      flags_coaszp = {~carry_out, sub_of, ~carry_nibble, top, zero, parity};
    end else begin
      flags_coaszp = {3'b000, top, zero, parity};
    end
  end

  always_comb begin
    done            = stage;
    done.flags      = alu_flags_t'(flags_coaszp);
    done.sets_flags = sets;
  end

  assign done_valid = stage_valid;

endmodule

//--- logic/result_queue.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module result_queue import alu_result_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  alu_result_t done,
  input  logic        done_valid,
  output alu_result_t result,
  output logic        result_valid,
  input  logic        result_credit,
  output logic        issue_credit
);

  localparam int DEPTH  = `ALU_QUEUE_DEPTH;
  localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int CRED_W = $clog2(`ALU_SINK_CREDITS + 1);

  alu_result_t       mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CRED_W-1:0] sink_credits;
  logic              pop;

  // one pop per cycle while data and a sink credit are there
  assign pop = (count != '0) && (sink_credits != '0);

  assign result       = mem[rd_ptr];
  assign result_valid = pop;
  assign issue_credit = pop;  // entry freed

  always_ff @(posedge clk) begin
    if (done_valid) begin
      mem[wr_ptr] <= done;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      sink_credits <= CRED_W'(`ALU_SINK_CREDITS);
    end else begin
      if (done_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({done_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      case ({pop, result_credit})
        2'b10:   sink_credits <= sink_credits - 1'b1;
        2'b01:   sink_credits <= sink_credits + 1'b1;
        default: sink_credits <= sink_credits;  // spent and returned together
      endcase
    end
  end

endmodule

//--- verif/alu_tb.sv
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_tb import alu_op_pkg::*; import alu_result_pkg::*; ();

  localparam int DEPTH   = `ALU_QUEUE_DEPTH;
  localparam int SINK    = `ALU_SINK_CREDITS;
  localparam int N_RAND  = 40;
  localparam int NUM_OPS = N_RAND + 8 + N_RAND + 18 + 17 * 4 * 2 + 4 + DEPTH + SINK;
  localparam int LIMIT   = NUM_OPS * 10 + 200;

  logic        clk = 1'b0;
  logic        rst;
  alu_issue_t  issue;
  logic        issue_valid;
  logic        issue_credit;
  alu_result_t result;
  logic        result_valid;
  logic        result_credit = 1'b0;
  logic        hold_credits = 1'b0;  // sink keeps its credits back

  alu_result_t expected[$];
  alu_result_t head;
  alu_tag_t    next_tag;
  int          issued;
  int          returned;
  int          received;
  int          owed;
  int          cycles;
  int          value_errors;
  int          flag_errors;
  int          tag_errors;
  int          proto_errors;

  alu_core i_alu_core (
    .clk, .rst, .issue, .issue_valid, .issue_credit, .result, .result_valid, .result_credit
  );

  always #2 clk = ~clk;

  initial begin
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d results outstanding", cycles, expected.size());
    $display("** FAIL **");
    $finish;
  end

  // issue credits seen before the edge
  always @(posedge clk) begin
    if (rst) begin
      returned <= 0;
    end else if (issue_credit) begin
      returned <= returned + 1;
    end
  end

  function automatic int credits_left();
    return DEPTH - issued + returned;
  endfunction

  function automatic alu_data_t rnd64();
    return {$urandom(), $urandom()};
  endfunction

  function automatic logic cond_true(input alu_flags_t f, input alu_cond_e cc);
    logic       lt;
    logic       base;
    logic [4:0] code;
    code = cc;
    lt = f.s ^ f.o;
    if (cc == ALWAYS) return 1'b1;
    case (code[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.s;
      3'd2:    base = ~(f.c | f.z);  // above
      3'd3:    base = ~f.c;
      3'd4:    base = ~(lt | f.z);   // signed greater
      3'd5:    base = ~lt;
      3'd6:    base = f.o;
      default: base = f.p;
    endcase
    return base ^ code[0];  // odd codes negate
  endfunction

  function automatic alu_result_t model(input alu_issue_t op);
    alu_result_t r;
    alu_data_t   mask;
    alu_data_t   a;
    alu_data_t   b;
    alu_data_t   v;
    alu_flags_t  f;
    logic [64:0] wide;
    logic        sa;
    logic        sv;
    logic        flagged;
    int          top_bit;
    mask = (op.size == SZ32) ? 64'h0000_0000_ffff_ffff : '1;
    top_bit = (op.size == SZ32) ? 31 : 63;
    a = op.a & mask;
    b = op.b & mask;
    wide = {1'b0, a} + {1'b0, b};
    f = '0;
    case (op.opcode)
      ADD:     v = wide[63:0];
      SUB:     v = a - b;
      AND:     v = a & b;
      OR:      v = a | b;
      XOR:     v = a ^ b;
      MOV:     v = op.b;
      ZXT8:    v = {56'h0, op.b[7:0]};
      ZXT16:   v = {48'h0, op.b[15:0]};
      SXT8:    v = {{56{op.b[7]}}, op.b[7:0]};
      SXT16:   v = {{48{op.b[15]}}, op.b[15:0]};
      SXT32:   v = {{32{op.b[31]}}, op.b[31:0]};
      CMOV:    v = cond_true(alu_flags_t'(op.flags_in), op.cond) ? op.b : op.a;
      CSET:    v = {63'h0, cond_true(alu_flags_t'(op.flags_in), op.cond)};
      default: v = '0;
    endcase
    v = v & mask;
    sa = a[top_bit];
    sv = v[top_bit];
    flagged = (op.opcode inside {ADD, SUB, AND, OR, XOR}) && !op.no_flags;
    if (flagged) begin
      f.s = sv;
      f.z = (v == '0);
      f.p = ~^v[7:0];
      if (op.opcode == ADD) begin
        f.c = (op.size == SZ32) ? wide[32] : wide[64];
        f.a = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
        f.o = (sa == b[top_bit]) && (sv != sa);
      end else if (op.opcode == SUB) begin
        f.c = a < b;  // borrow
        f.a = a[3:0] < b[3:0];
        f.o = (sa != b[top_bit]) && (sv != sa);
      end
    end
    r.tag = op.tag;
    r.value = v;
    r.flags = f;
    r.sets_flags = flagged;
    return r;
  endfunction

  task automatic check_value(input alu_data_t got, input alu_data_t exp, input alu_tag_t t);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %0t: tag %0d value %h, expected %h", $time, t, got, exp);
    end
  endtask

  task automatic check_flags(input alu_flags_t got, input logic got_sets, input alu_flags_t exp,
                             input logic exp_sets, input alu_tag_t t);
    if (got !== exp || got_sets !== exp_sets) begin
      flag_errors++;
      $display("FAIL %0t: tag %0d flags %b sets %b, expected %b sets %b", $time, t, got,
               got_sets, exp, exp_sets);
    end
  endtask

  task automatic check_tag(input alu_tag_t got, input alu_tag_t exp);
    if (got !== exp) begin
      tag_errors++;
      $display("FAIL %0t: tag %0d out of order, expected %0d", $time, got, exp);
    end
  endtask

  // sink takes results on the falling edge
  always @(negedge clk) begin
    result_credit = 1'b0;
    if (!rst && result_valid) begin
      received++;
      owed++;
      if (expected.size() == 0) begin
        proto_errors++;
        $display("result with tag %0d arrived but none was expected", result.tag);
      end else begin
        head = expected.pop_front();
        check_tag(result.tag, head.tag);
        check_value(result.value, head.value, head.tag);
        check_flags(result.flags, result.sets_flags, head.flags, head.sets_flags, head.tag);
      end
    end
    if (!hold_credits && owed > 0) begin
      result_credit = 1'b1;
      owed--;
    end
  end

  task automatic send(input alu_opcode_e opc, input alu_size_e sz, input alu_data_t a,
                      input alu_data_t b, input logic nf, input alu_cond_e cc,
                      input logic [`ALU_FLAGS_W-1:0] fl);
    alu_issue_t op;
    while (credits_left() == 0) @(negedge clk);
    op = '{tag: next_tag, opcode: opc, size: sz, cond: cc, no_flags: nf,
           a: a, b: b, flags_in: fl};
    expected.push_back(model(op));
    issue = op;
    issue_valid = 1'b1;
    issued++;
    next_tag++;
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  task automatic issue_plain(input alu_opcode_e opc, input alu_size_e sz, input alu_data_t a,
                             input alu_data_t b);
    send(opc, sz, a, b, 1'b0, ALWAYS, '0);
  endtask

  task automatic wait_drain();
    while (expected.size() != 0 || credits_left() != DEPTH) @(negedge clk);
  endtask

  task automatic add_sub_mix();
    issue_plain(ADD, SZ64, '1, 64'd1);
    issue_plain(ADD, SZ64, 64'h7fff_ffff_ffff_ffff, 64'd1);
    issue_plain(ADD, SZ64, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);
    issue_plain(SUB, SZ64, 64'd0, 64'd1);
    issue_plain(SUB, SZ64, 64'h8000_0000_0000_0000, 64'd1);
    issue_plain(ADD, SZ32, 64'hdead_beef_ffff_ffff, 64'd1);  // upper half ignored
    issue_plain(ADD, SZ32, 64'h7fff_ffff, 64'h1234_5678_0000_0001);
    issue_plain(SUB, SZ32, 64'h8000_0000, 64'd1);
    for (int i = 0; i < N_RAND; i++) begin
      issue_plain(($urandom() % 2 == 1) ? SUB : ADD, ($urandom() % 2 == 1) ? SZ32 : SZ64,
                  rnd64(), rnd64());
    end
    wait_drain();
  endtask

  task automatic logic_mix();
    alu_data_t   x;
    alu_opcode_e opc;
    for (int i = 0; i < N_RAND; i++) begin
      x = rnd64();
      opc = (i % 8 == 0) ? XOR : alu_opcode_e'(4'(2 + $urandom() % 3));  // zero result
      issue_plain(opc, ($urandom() % 2 == 1) ? SZ32 : SZ64, x, (i % 8 == 0) ? x : rnd64());
    end
    wait_drain();
  endtask

  task automatic move_extend();
    alu_opcode_e moves[6] = '{MOV, ZXT8, ZXT16, SXT8, SXT16, SXT32};
    alu_data_t   vals[3] = '{64'h0123_4567_89ab_cdef, 64'hffff_ffff_8000_80f0, 64'h7f};
    for (int j = 0; j < 3; j++) begin
      for (int k = 0; k < 6; k++) issue_plain(moves[k], (j == 2) ? SZ32 : SZ64, rnd64(), vals[j]);
    end
    wait_drain();
  endtask

  task automatic cond_sweep();
    logic [`ALU_FLAGS_W-1:0] pats[4] = '{6'b000000, 6'b111111, 6'b010000, 6'b100101};
    for (int i = 0; i <= 16; i++) begin
      for (int j = 0; j < 4; j++) begin
        send(CMOV, SZ64, rnd64(), rnd64(), 1'b0, alu_cond_e'(5'(i)), pats[j]);
        send(CSET, SZ64, '1, '1, 1'b0, alu_cond_e'(5'(i)), pats[j]);
      end
    end
    wait_drain();
  endtask

  task automatic suppressed_flags();
    send(ADD, SZ64, '1, 64'd1, 1'b1, ALWAYS, '0);
    send(SUB, SZ32, 64'd0, 64'd1, 1'b1, ALWAYS, '0);
    send(AND, SZ64, 64'hf0f0, 64'h0f0f, 1'b1, ALWAYS, '0);
    send(XOR, SZ64, 64'h8000_0000_0000_0001, 64'd1, 1'b1, ALWAYS, '0);
    wait_drain();
  endtask

  task automatic hold_and_release();
    int base;
    @(posedge clk);
    hold_credits = 1'b1;
    @(negedge clk);
    base = received;
    // enough to fill the queue behind the two results the sink can take
    for (int i = 0; i < DEPTH + SINK; i++) issue_plain(ADD, SZ64, rnd64(), rnd64());
    while (received < base + SINK) @(negedge clk);
    repeat (2 * DEPTH) @(negedge clk);
    if (received != base + SINK) begin
      proto_errors++;
      $display("%0d results left while the sink held its credits, expected %0d",
               received - base, SINK);
    end
    if (credits_left() != 0) begin
      proto_errors++;
      $display("issuer still holds %0d credits with the queue full", credits_left());
    end
    @(posedge clk);
    hold_credits = 1'b0;
    @(negedge clk);
    wait_drain();
  endtask

  initial begin
    void'($urandom(40493));
    rst = 1'b1;
    issue = '0;
    issue_valid = 1'b0;
    next_tag = '0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    add_sub_mix();
    logic_mix();
    move_extend();
    cond_sweep();
    suppressed_flags();
    hold_and_release();
    if (received != issued) begin
      proto_errors++;
      $display("%0d operations issued but %0d results received", issued, received);
    end
    $display("errors: value %0d, flags %0d, tag %0d, protocol %0d", value_errors, flag_errors,
             tag_errors, proto_errors);
    if (value_errors + flag_errors + tag_errors + proto_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
